// File: rtl/dataCache_macros.svh
`ifndef DATACACHE_MACROS_SVH
`define DATACACHE_MACROS_SVH

// processor side widths
`define DC_ADDR_WIDTH 32
`define DC_WORD_WIDTH 32

// cache organization
`define DC_SETS 4
`define DC_WAYS 4
`define DC_WORDS_PER_LINE 4

// derived line geometry
`define DC_BYTES_PER_WORD (`DC_WORD_WIDTH / 8)
`define DC_WORD_OFFSET ($clog2(`DC_BYTES_PER_WORD))
`define DC_LINE_OFFSET (`DC_WORD_OFFSET + $clog2(`DC_WORDS_PER_LINE))

// tag starts above the set index
`define DC_TAG_OFFSET (`DC_LINE_OFFSET + $clog2(`DC_SETS))

`endif

// File: rtl/dataCachePkg.sv
`include "dataCache_macros.svh"

package dataCachePkg;

	typedef logic [`DC_ADDR_WIDTH-1:0] addrT;
	typedef logic [`DC_WORD_WIDTH-1:0] wordT;

	// address fields
	typedef logic [`DC_ADDR_WIDTH-`DC_TAG_OFFSET-1:0] tagT;
	typedef logic [$clog2(`DC_SETS)-1:0] setT;
	typedef logic [$clog2(`DC_WORDS_PER_LINE)-1:0] wordSelT;

	typedef logic [$clog2(`DC_WAYS)-1:0] wayT;

	// one enable per byte lane
	typedef logic [`DC_BYTES_PER_WORD-1:0] byteMaskT;

	typedef enum logic [1:0]
	{
		idle,
		readIn,
		writeBack
	} cacheStateT;

endpackage

// File: rtl/arrayIf.sv
interface arrayIf
	import dataCachePkg::*;
();

	// write port, byte masked
	logic wrEnable;
	byteMaskT wrMask;
	setT wrSet;
	wayT wrWay;
	wordSelT wrWord;
	wordT wrData;

	// read port
	setT rdSet;
	wayT rdWay;
	wordSelT rdWord;
	wordT rdData;

	modport controller (output wrEnable, wrMask, wrSet, wrWay, wrWord, wrData,
		output rdSet, rdWay, rdWord, input rdData);

	modport storage (input wrEnable, wrMask, wrSet, wrWay, wrWord, wrData,
		input rdSet, rdWay, rdWord, output rdData);

endinterface

// File: rtl/tagIf.sv
interface tagIf
	import dataCachePkg::*;
();

	// lookup results for the current address
	logic hit;
	wayT hitWay;
	wayT victimWay;
	logic victimValid;
	logic victimDirty;
	tagT victimTag;

	// directory updates
	logic markDirty;
	wayT dirtyWay;
	logic fillDone;
	setT fillSet;
	tagT fillTag;
	logic invalidate;
	setT invSet;

	modport directory (output hit, hitWay, victimWay, victimValid, victimDirty, victimTag,
		input markDirty, dirtyWay, fillDone, fillSet, fillTag, invalidate, invSet);

	modport controller (input hit, hitWay, victimWay, victimValid, victimDirty, victimTag,
		output markDirty, dirtyWay, fillDone, fillSet, fillTag, invalidate, invSet);

endinterface

// File: rtl/tagDirectory.sv
`include "dataCache_macros.svh"

module tagDirectory
	import dataCachePkg::*;
(
	input logic clock,
	input logic reset,
	input addrT address,
	tagIf.directory tags
);

	tagT tagStore [`DC_SETS][`DC_WAYS];
	logic [`DC_WAYS-1:0] valid [`DC_SETS];
	logic [`DC_WAYS-1:0] dirty [`DC_SETS];
	wayT lastFill [`DC_SETS];

	// replacement choice for every set
	wayT victimOf [`DC_SETS];

	setT curSet;
	tagT curTag;

	assign curSet = address[`DC_TAG_OFFSET-1:`DC_LINE_OFFSET];
	assign curTag = address[`DC_ADDR_WIDTH-1:`DC_TAG_OFFSET];

	// lowest invalid way wins, else the way after the last fill
	always_comb
	begin
		for (int s = 0; s < `DC_SETS; s++)
		begin
			victimOf[s] = lastFill[s] + wayT'(1);
			for (int w = `DC_WAYS - 1; w >= 0; w--)
			begin
				if (!valid[s][w])
				begin
					victimOf[s] = wayT'(w);
				end
			end
		end
	end

	// tags in a set are distinct, so at most one way matches
	always_comb
	begin
		tags.hit = 1'b0;
		tags.hitWay = '0;
		for (int w = 0; w < `DC_WAYS; w++)
		begin
			if (valid[curSet][w] && tagStore[curSet][w] == curTag)
			begin
				tags.hit = 1'b1;
				tags.hitWay = wayT'(w);
			end
		end
	end

	assign tags.victimWay = victimOf[curSet];
	assign tags.victimValid = valid[curSet][victimOf[curSet]];
	assign tags.victimDirty = dirty[curSet][victimOf[curSet]];
	assign tags.victimTag = tagStore[curSet][victimOf[curSet]];

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			for (int s = 0; s < `DC_SETS; s++)
			begin
				valid[s] <= '0;
				dirty[s] <= '0;
				lastFill[s] <= '0;
			end
		end
		else
		begin
			if (tags.fillDone)
			begin
				valid[tags.fillSet][victimOf[tags.fillSet]] <= 1'b1;
				dirty[tags.fillSet][victimOf[tags.fillSet]] <= 1'b0;
				lastFill[tags.fillSet] <= victimOf[tags.fillSet];
			end
			if (tags.invalidate)
			begin
				valid[tags.invSet][victimOf[tags.invSet]] <= 1'b0;
			end
			if (tags.markDirty)
			begin
				dirty[curSet][tags.dirtyWay] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (tags.fillDone)
		begin
			tagStore[tags.fillSet][victimOf[tags.fillSet]] <= tags.fillTag;
		end
	end

endmodule

// File: rtl/dataArray.sv
`include "dataCache_macros.svh"

module dataArray
	import dataCachePkg::*;
(
	input logic clock,
	arrayIf.storage array
);

	// one byte per entry, lane 0 is the low byte of a word
	logic [7:0] bytes [`DC_SETS][`DC_WAYS][`DC_WORDS_PER_LINE][`DC_BYTES_PER_WORD];

	// asynchronous word read
	always_comb
	begin
		for (int b = 0; b < `DC_BYTES_PER_WORD; b++)
		begin
			array.rdData[b*8 +: 8] = bytes[array.rdSet][array.rdWay][array.rdWord][b];
		end
	end

	// only the lanes selected by the mask change
	always_ff @(posedge clock)
	begin
		if (array.wrEnable)
		begin
			for (int b = 0; b < `DC_BYTES_PER_WORD; b++)
			begin
				if (array.wrMask[b])
				begin
					bytes[array.wrSet][array.wrWay][array.wrWord][b] <= array.wrData[b*8 +: 8];
				end
			end
		end
	end

endmodule

// File: rtl/cacheController.sv
`include "dataCache_macros.svh"

module cacheController
	import dataCachePkg::*;
(
	input logic clock,
	input logic reset,
	input addrT address,
	input wordT writeData,
	input logic accessEnable,
	input logic byteAccess,
	input logic read,
	output wordT readData,
	output logic cacheWait,
	output addrT memAddress,
	output wordT memWriteData,
	output logic memEnable,
	output logic memRead,
	input wordT memReadData,
	input logic memWait,
	tagIf.controller tags,
	arrayIf.controller array
);

	cacheStateT state;
	logic seenWait;
	wordSelT wordCount;

	// miss context, captured when the miss is taken
	setT missSet;
	tagT wbTag;
	tagT reqTag;

	tagT addrTag;
	setT reqSet;
	wordSelT reqWord;
	logic [`DC_WORD_OFFSET-1:0] byteSel;
	logic [7:0] hitByte;
	logic miss;
	logic readHit;
	logic writeHit;
	logic wordDone;
	logic lastWord;

	assign addrTag = address[`DC_ADDR_WIDTH-1:`DC_TAG_OFFSET];
	assign reqSet = address[`DC_TAG_OFFSET-1:`DC_LINE_OFFSET];
	assign reqWord = address[`DC_LINE_OFFSET-1:`DC_WORD_OFFSET];
	assign byteSel = address[`DC_WORD_OFFSET-1:0];
	assign hitByte = array.rdData[byteSel*8 +: 8];

	assign miss = state == idle && accessEnable && !tags.hit;
	assign readHit = state == idle && accessEnable && tags.hit && read;
	assign writeHit = state == idle && accessEnable && tags.hit && !read;

	// a word moves once memWait has been high and is low again
	assign wordDone = seenWait && !memWait;
	assign lastWord = wordCount == wordSelT'(`DC_WORDS_PER_LINE - 1);

	assign memEnable = state != idle;
	assign memRead = state == readIn;
	assign memWriteData = (state == writeBack) ? array.rdData : '0;

	always_comb
	begin
		case (state)
			writeBack: memAddress = {wbTag, missSet, wordCount, {`DC_WORD_OFFSET{1'b0}}};
			readIn: memAddress = {reqTag, missSet, wordCount, {`DC_WORD_OFFSET{1'b0}}};
			default: memAddress = '0;
		endcase
	end

	// hit access by default, victim line while a miss is in progress
	always_comb
	begin
		array.rdSet = reqSet;
		array.rdWay = tags.hitWay;
		array.rdWord = reqWord;
		array.wrEnable = writeHit;
		array.wrSet = reqSet;
		array.wrWay = tags.hitWay;
		array.wrWord = reqWord;
		array.wrMask = byteAccess ? byteMaskT'(1) << byteSel : '1;
		array.wrData = byteAccess ? {`DC_BYTES_PER_WORD{writeData[7:0]}} : writeData;
		if (state == writeBack)
		begin
			array.rdSet = missSet;
			array.rdWay = tags.victimWay;
			array.rdWord = wordCount;
		end
		else if (state == readIn)
		begin
			array.wrEnable = wordDone;
			array.wrSet = missSet;
			array.wrWay = tags.victimWay;
			array.wrWord = wordCount;
			array.wrMask = '1;
			array.wrData = memReadData;
		end
	end

	assign tags.markDirty = writeHit;
	assign tags.dirtyWay = tags.hitWay;
	assign tags.fillDone = state == readIn && wordDone && lastWord;
	assign tags.fillSet = missSet;
	assign tags.fillTag = reqTag;
	assign tags.invalidate = state == writeBack && wordDone && lastWord;
	assign tags.invSet = missSet;

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			state <= idle;
			cacheWait <= 1'b0;
			seenWait <= 1'b0;
			wordCount <= '0;
			readData <= '0;
		end
		else if (state == idle)
		begin
			cacheWait <= miss;
			seenWait <= 1'b0;
			wordCount <= '0;
			if (miss)
			begin
				// dirty victim goes back to memory before the fill
				state <= (tags.victimValid && tags.victimDirty) ? writeBack : readIn;
			end
			else if (readHit)
			begin
				readData <= byteAccess ? {`DC_BYTES_PER_WORD{hitByte}} : array.rdData;
			end
		end
		else if (memWait)
		begin
			seenWait <= 1'b1;
		end
		else if (seenWait)
		begin
			seenWait <= 1'b0;
			wordCount <= wordCount + wordSelT'(1);
			// back to idle with cacheWait still high, the request is retried
			if (lastWord)
			begin
				state <= idle;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (miss)
		begin
			missSet <= reqSet;
			wbTag <= tags.victimTag;
			reqTag <= addrTag;
		end
	end

endmodule

// File: rtl/dataCache.sv
module dataCache
	import dataCachePkg::*;
(
	input logic clock,
	input logic reset,
	input addrT address,
	input wordT writeData,
	input logic accessEnable,
	input logic byteAccess,
	input logic read,
	output wordT readData,
	output logic cacheWait,
	output addrT memAddress,
	output wordT memWriteData,
	output logic memEnable,
	output logic memRead,
	input wordT memReadData,
	input logic memWait
);

	arrayIf arrayBus ();
	tagIf tagBus ();

	tagDirectory directory (
		.clock(clock),
		.reset(reset),
		.address(address),
		.tags(tagBus.directory)
	);

	dataArray storage (
		.clock(clock),
		.array(arrayBus.storage)
	);

	cacheController controller (
		.clock(clock),
		.reset(reset),
		.address(address),
		.writeData(writeData),
		.accessEnable(accessEnable),
		.byteAccess(byteAccess),
		.read(read),
		.readData(readData),
		.cacheWait(cacheWait),
		.memAddress(memAddress),
		.memWriteData(memWriteData),
		.memEnable(memEnable),
		.memRead(memRead),
		.memReadData(memReadData),
		.memWait(memWait),
		.tags(tagBus.controller),
		.array(arrayBus.controller)
	);

endmodule

// File: tests/dataCacheTb.sv
`include "dataCache_macros.svh"

module dataCacheTb
	import dataCachePkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	logic clock;
	logic reset;
	addrT address;
	wordT writeData;
	logic accessEnable;
	logic byteAccess;
	logic read;
	wordT readData;
	logic cacheWait;
	addrT memAddress;
	wordT memWriteData;
	logic memEnable;
	logic memRead;
	wordT memReadData;
	logic memWait;

	int errors;
	int timeouts;
	int waitCycles;

	// sparse memory model and its transfer logs
	wordT memStore [addrT];
	addrT readLog [$];
	addrT writeAddrLog [$];
	wordT writeDataLog [$];
	int waitLeft;

	dataCache uut (.*);

	always #5 clock = ~clock;

	// untouched words hash their full address
	function automatic wordT memInit(input addrT a);
		return (a * 32'h9e37_79b1) ^ 32'h5ac3_0f69;
	endfunction

	function automatic wordT memValue(input addrT a);
		if (memStore.exists(a))
		begin
			return memStore[a];
		end
		return memInit(a);
	endfunction

	function automatic addrT makeAddr(input int tag, input int set, input int word);
		return (addrT'(tag) << `DC_TAG_OFFSET) | (addrT'(set) << `DC_LINE_OFFSET)
			| (addrT'(word) << `DC_WORD_OFFSET);
	endfunction

	function automatic wordT mergeByte(input wordT w, input int lane, input logic [7:0] b);
		wordT r;
		r = w;
		r[lane*8 +: 8] = b;
		return r;
	endfunction

	// memWait high for 1 to 3 cycles, then low for the cycle the word moves
	always @(posedge clock)
	begin
		#1;
		if (waitLeft > 0)
		begin
			waitLeft--;
			if (waitLeft == 0)
			begin
				memWait = 1'b0;
				if (memRead)
				begin
					memReadData = memValue(memAddress);
					readLog.push_back(memAddress);
				end
				else
				begin
					memStore[memAddress] = memWriteData;
					writeAddrLog.push_back(memAddress);
					writeDataLog.push_back(memWriteData);
				end
			end
		end
		else if (memEnable)
		begin
			memWait = 1'b1;
			waitLeft = $urandom_range(3, 1);
		end
	end

	task automatic checkWord(input string name, input wordT got, input wordT exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkAddr(input string name, input addrT got, input addrT exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	// holds the request until cacheWait is seen low after an edge
	task automatic access(input addrT a, input logic rd, input logic bt, input wordT wd);
		address = a;
		read = rd;
		byteAccess = bt;
		writeData = wd;
		accessEnable = 1'b1;
		waitCycles = 0;
		@(posedge clock);
		#1;
		while (cacheWait && waitCycles < 100)
		begin
			@(posedge clock);
			#1;
			waitCycles++;
		end
		if (cacheWait)
		begin
			$display("timeout: cacheWait still high 100 cycles after access to %h", a);
			timeouts++;
		end
		accessEnable = 1'b0;
	endtask

	task automatic readWord(input addrT a, input wordT exp);
		access(a, 1'b1, 1'b0, '0);
		checkWord("readData", readData, exp);
	endtask

	task automatic readByte(input addrT a, input logic [7:0] exp);
		access(a, 1'b1, 1'b1, '0);
		checkWord("readData", readData, {`DC_BYTES_PER_WORD{exp}});
	endtask

	// line words 0 to 3 read in order, nothing more
	task automatic fillReads(input addrT lineBase, input int first);
		checkCount("memory reads", readLog.size() - first, `DC_WORDS_PER_LINE);
		for (int i = 0; i < `DC_WORDS_PER_LINE && first + i < readLog.size(); i++)
		begin
			checkAddr("memAddress", readLog[first + i],
				lineBase + addrT'(i * `DC_BYTES_PER_WORD));
		end
	endtask

	task automatic missRead(input int tag, input int set, input int word);
		int first;
		first = readLog.size();
		readWord(makeAddr(tag, set, word), memValue(makeAddr(tag, set, word)));
		checkBit("cacheWait raised", waitCycles > 0, 1'b1);
		fillReads(makeAddr(tag, set, 0), first);
	endtask

	task automatic hitRead(input int tag, input int set, input int word);
		int first;
		first = readLog.size();
		readWord(makeAddr(tag, set, word), memValue(makeAddr(tag, set, word)));
		checkCount("cacheWait cycles", waitCycles, 0);
		checkCount("memory reads", readLog.size() - first, 0);
	endtask

	task automatic resetState();
		checkBit("cacheWait", cacheWait, 1'b0);
		checkBit("memEnable", memEnable, 1'b0);
		checkBit("memRead", memRead, 1'b0);
		checkWord("readData", readData, '0);
	endtask

	task automatic coldReadMiss();
		missRead(1, 0, 1);
		hitRead(1, 0, 3);
	endtask

	task automatic writeHits();
		int reads;
		int writes;
		addrT a;
		a = makeAddr(1, 0, 2);
		reads = readLog.size();
		writes = writeAddrLog.size();
		access(a, 1'b0, 1'b0, 32'h1234_5678);
		access(a + 1, 1'b0, 1'b1, 32'h0000_00a5);
		readWord(a, mergeByte(32'h1234_5678, 1, 8'ha5));
		readByte(a + 1, 8'ha5);
		readByte(a + 3, 8'h12);
		checkCount("memory reads", readLog.size() - reads, 0);
		checkCount("memory writes", writeAddrLog.size() - writes, 0);
	endtask

	task automatic replacementOrder();
		int writes;
		writes = writeAddrLog.size();
		for (int t = 10; t < 14; t++)
		begin
			missRead(t, 1, 0);
		end
		for (int t = 10; t < 14; t++)
		begin
			hitRead(t, 1, 2);
		end
		// way 0 holds the oldest fill
		missRead(14, 1, 0);
		for (int t = 11; t < 15; t++)
		begin
			hitRead(t, 1, 1);
		end
		missRead(10, 1, 3);
		checkCount("memory writes", writeAddrLog.size() - writes, 0);
	endtask

	task automatic dirtyWriteBack();
		int writes;
		wordT expected [`DC_WORDS_PER_LINE];
		for (int t = 20; t < 24; t++)
		begin
			missRead(t, 2, 0);
		end
		for (int i = 0; i < `DC_WORDS_PER_LINE; i++)
		begin
			expected[i] = memValue(makeAddr(20, 2, i));
		end
		access(makeAddr(20, 2, 1), 1'b0, 1'b0, 32'hcafe_f00d);
		access(makeAddr(20, 2, 3), 1'b0, 1'b1, 32'h0000_003c);
		expected[1] = 32'hcafe_f00d;
		expected[3] = mergeByte(expected[3], 0, 8'h3c);
		writes = writeAddrLog.size();
		missRead(24, 2, 0);
		checkCount("memory writes", writeAddrLog.size() - writes, `DC_WORDS_PER_LINE);
		for (int i = 0; i < `DC_WORDS_PER_LINE && writes + i < writeAddrLog.size(); i++)
		begin
			checkAddr("memAddress", writeAddrLog[writes + i], makeAddr(20, 2, i));
			checkWord("memWriteData", writeDataLog[writes + i], expected[i]);
		end
		// the evicted line comes back with the written word
		missRead(20, 2, 1);
		checkWord("readData", readData, 32'hcafe_f00d);
	endtask

	task automatic writeMiss();
		int first;
		addrT a;
		a = makeAddr(30, 3, 2);
		first = readLog.size();
		access(a + 2, 1'b0, 1'b1, 32'h0000_0077);
		checkBit("cacheWait raised", waitCycles > 0, 1'b1);
		fillReads(makeAddr(30, 3, 0), first);
		readWord(a, mergeByte(memValue(a), 2, 8'h77));
		checkCount("memory reads", readLog.size() - first, `DC_WORDS_PER_LINE);
	endtask

	initial
	begin
		void'($urandom(32'hb547));
		errors = 0;
		timeouts = 0;
		waitCycles = 0;
		waitLeft = 0;
		clock = 1'b0;
		reset = 1'b0;
		address = '0;
		writeData = '0;
		accessEnable = 1'b0;
		byteAccess = 1'b0;
		read = 1'b0;
		memReadData = '0;
		memWait = 1'b0;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b1;

		resetState();
		coldReadMiss();
		writeHits();
		replacementOrder();
		dirtyWriteBack();
		writeMiss();

		$display("value errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
		begin
			$display("Verification passed");
		end
		else
		begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: all.f
+incdir+rtl
rtl/dataCachePkg.sv
rtl/arrayIf.sv
rtl/tagIf.sv
rtl/tagDirectory.sv
rtl/dataArray.sv
rtl/cacheController.sv
rtl/dataCache.sv
tests/dataCacheTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --top-module dataCacheTb -f all.f
./obj_dir/VdataCacheTb | tee run.log

if grep -q "Verification failed" run.log
then
	exit 1
fi
